//--- source/core_consts.svh
// Widths, depths and RISC-V encodings for the two-way core
// WAYS is fixed at 2; the buffer shift and dispatch count assume it
// ROB_TAG_BITS must equal log2 of ROB_ENTRIES
// XLEN is assumed to be 32 by the immediate decode
`ifndef CORE_CONSTS_SVH
`define CORE_CONSTS_SVH

// Machine shape
`define WAYS          2
`define XLEN          32
`define ROB_ENTRIES   8
`define ROB_TAG_BITS  3
`define N_ARCH_REG    32
`define REG_IDX_BITS  5

// Encodings
`define RV_OPC_LUI    7'b0110111
`define RV_OPC_ADDI   7'b0010011
`define RV_INST_WFI   32'h10500073
`define RV_INST_NOP   32'h00000013

`endif

//--- source/core_pkg.sv
// Types passed between fetch, dispatch, execute, ROB and register file
// Field widths come from core_consts.svh
// WFI is decoded but never reaches the ALUs

`default_nettype none

`include "core_consts.svh"

package core_pkg;

	// Decoded operation
	typedef enum logic [1:0] {
		OP_LUI,
		OP_ADDI,
		OP_WFI
	} op_t;

	// One fetch/dispatch buffer slot
	typedef struct packed {
		logic               valid;
		logic [`XLEN-1:0]   pc;
		logic [31:0]        inst;
	} fetch_slot_t;

	// ROB allocation request from dispatch
	typedef struct packed {
		logic                      valid;
		logic [`XLEN-1:0]          pc;
		logic [`REG_IDX_BITS-1:0]  rd;
		logic                      is_wfi;
	} rob_alloc_t;

	// Work for one ALU
	typedef struct packed {
		logic                      valid;
		logic [`ROB_TAG_BITS-1:0]  tag;
		op_t                       op;
		logic [`XLEN-1:0]          rs1_val;
		logic [`XLEN-1:0]          imm;
	} exec_req_t;

	// ALU result back to the ROB
	typedef struct packed {
		logic                      valid;
		logic [`ROB_TAG_BITS-1:0]  tag;
		logic [`XLEN-1:0]          value;
	} complete_t;

	// In-order retirement into the register file
	typedef struct packed {
		logic                      valid;
		logic [`XLEN-1:0]          pc;
		logic [`REG_IDX_BITS-1:0]  rd;
		logic [`XLEN-1:0]          value;
	} retire_t;

endpackage

`default_nettype wire

//--- source/fetch_stage.sv
// PC and two-entry fetch/dispatch buffer
// Instruction memory must answer imem_addr in the same cycle
// Slots are kept packed toward slot 0; the PC points past the last one

`default_nettype none

`include "core_consts.svh"

module fetch_stage (
	input  wire                                clock,
	input  wire                                arst_n,
	input  wire                                halt,
	input  wire  [1:0]                         dispatch_count,
	input  wire  [`WAYS-1:0][`XLEN-1:0]        imem_data,
	output logic [`WAYS-1:0][`XLEN-1:0]        imem_addr,
	output core_pkg::fetch_slot_t [`WAYS-1:0]  slots
);
	import core_pkg::*;

	logic [`XLEN-1:0]         pc_q;
	logic [`XLEN-1:0]         pc_d;
	fetch_slot_t [`WAYS-1:0]  fdb_q;
	fetch_slot_t [`WAYS-1:0]  fdb_d;

	// Sequential pair starting at the PC
	always_comb begin
		for (int i = 0; i < `WAYS; i++) begin
			imem_addr[i] = pc_q + `XLEN'(4 * i);
		end
	end

	// Shift out accepted slots, refill from the fetched pair
	always_comb begin
		int n_valid;
		int keep;
		int src;
		n_valid = 0;
		for (int i = 0; i < `WAYS; i++) begin
			n_valid = n_valid + int'(fdb_q[i].valid);
		end
		// Slots still waiting after this cycle
		keep = n_valid - int'(dispatch_count);
		for (int i = 0; i < `WAYS; i++) begin
			if (i < keep) begin
				src = i + int'(dispatch_count);
				fdb_d[i] = fdb_q[src];
			end else begin
				src = i - keep;
				fdb_d[i].valid = 1'b1;
				fdb_d[i].pc    = imem_addr[src];
				fdb_d[i].inst  = imem_data[src];
			end
		end
		// Advance over every word just pulled in
		pc_d = pc_q + `XLEN'(4 * (`WAYS - keep));
	end

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			pc_q <= '0;
			for (int i = 0; i < `WAYS; i++) begin
				fdb_q[i].valid <= 1'b0;
				fdb_q[i].pc    <= '0;
				fdb_q[i].inst  <= `RV_INST_NOP;
			end
		end else if (halt) begin
			// Halted, PC frozen and buffer emptied
			for (int i = 0; i < `WAYS; i++) begin
				fdb_q[i].valid <= 1'b0;
			end
		end else begin
			pc_q  <= pc_d;
			fdb_q <= fdb_d;
		end
	end

	// Nothing is offered once the core has halted
	always_comb begin
		for (int i = 0; i < `WAYS; i++) begin
			slots[i]       = fdb_q[i];
			slots[i].valid = fdb_q[i].valid & ~halt;
		end
	end

endmodule

`default_nettype wire

//--- source/dispatch_stage.sv
// Decode, hazard check and ROB allocation for the buffered pair
// Purely combinational; accepts a leading run of 0, 1 or 2 slots
// ADDI waits while its rs1 has an uncommitted writer

`default_nettype none

`include "core_consts.svh"

module dispatch_stage (
	input  wire core_pkg::fetch_slot_t [`WAYS-1:0]  slots,
	input  wire  [`ROB_TAG_BITS-1:0]                alloc_tag,
	input  wire  [`ROB_TAG_BITS:0]                  free_count,
	input  wire  [`N_ARCH_REG-1:0]                  busy_regs,
	input  wire  [`WAYS-1:0][`XLEN-1:0]             rs1_value,
	output logic [1:0]                              dispatch_count,
	output logic [`WAYS-1:0][`REG_IDX_BITS-1:0]     rs1_idx,
	output core_pkg::rob_alloc_t [`WAYS-1:0]        alloc,
	output core_pkg::exec_req_t [`WAYS-1:0]         exec_req
);
	import core_pkg::*;

	op_t                               op [`WAYS];
	logic [`WAYS-1:0]                  legal;
	logic [`WAYS-1:0][`XLEN-1:0]       imm;
	logic [`WAYS-1:0][`REG_IDX_BITS-1:0] rd;
	logic [`WAYS-1:0]                  accept;

	// Decode
	always_comb begin
		for (int i = 0; i < `WAYS; i++) begin
			legal[i]   = 1'b1;
			rs1_idx[i] = slots[i].inst[19:15];
			rd[i]      = slots[i].inst[11:7];
			if (slots[i].inst == `RV_INST_WFI) begin
				op[i]  = OP_WFI;
				imm[i] = '0;
				rd[i]  = '0;
			end else if (slots[i].inst[6:0] == `RV_OPC_LUI) begin
				op[i]  = OP_LUI;
				imm[i] = {slots[i].inst[31:12], 12'b0};
			end else begin
				op[i]    = OP_ADDI;
				imm[i]   = {{20{slots[i].inst[31]}}, slots[i].inst[31:20]};
				// funct3 of ADDI is 000
				legal[i] = (slots[i].inst[6:0] == `RV_OPC_ADDI) &&
				           (slots[i].inst[14:12] == 3'b000);
			end
		end
	end

	// Acceptance, in order, stopping at the first refused slot
	always_comb begin
		logic older_ok;
		older_ok       = 1'b1;
		dispatch_count = '0;
		for (int i = 0; i < `WAYS; i++) begin
			accept[i] = older_ok && slots[i].valid && legal[i] && (free_count > i);
			if (op[i] == OP_ADDI) begin
				// Writer still in the ROB
				if (busy_regs[rs1_idx[i]]) begin
					accept[i] = 1'b0;
				end
				// Writer in an older way of this same pair
				for (int j = 0; j < i; j++) begin
					if (rs1_idx[i] != '0 && rs1_idx[i] == rd[j]) begin
						accept[i] = 1'b0;
					end
				end
			end
			older_ok = accept[i];
			dispatch_count = dispatch_count + 2'(accept[i]);
		end
	end

	// ROB entries and ALU requests for the accepted slots
	always_comb begin
		for (int i = 0; i < `WAYS; i++) begin
			alloc[i].valid  = accept[i];
			alloc[i].pc     = slots[i].pc;
			alloc[i].rd     = rd[i];
			alloc[i].is_wfi = (op[i] == OP_WFI);

			// WFI is born complete and skips the ALUs
			exec_req[i].valid   = accept[i] && (op[i] != OP_WFI);
			exec_req[i].tag     = alloc_tag + `ROB_TAG_BITS'(i);
			exec_req[i].op      = op[i];
			exec_req[i].rs1_val = rs1_value[i];
			exec_req[i].imm     = imm[i];
		end
	end

	// Only LUI, ADDI and WFI are supported
	always_comb begin
		for (int i = 0; i < `WAYS; i++) begin
			if (slots[i].valid) begin
				assert (legal[i])
					else $error("dispatch: unsupported inst %h at pc %h",
						slots[i].inst, slots[i].pc);
			end
		end
	end

endmodule

`default_nettype wire

//--- source/execute_unit.sv
// Dispatch/execute pipeline register and the two ALUs
// Results leave one cycle after dispatch
// WFI never arrives here

`default_nettype none

`include "core_consts.svh"

module execute_unit (
	input  wire                                  clock,
	input  wire                                  arst_n,
	input  wire core_pkg::exec_req_t [`WAYS-1:0] exec_req,
	output core_pkg::complete_t [`WAYS-1:0]      complete
);
	import core_pkg::*;

	logic [`WAYS-1:0]       valid_q;
	exec_req_t [`WAYS-1:0]  req_q;

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			valid_q <= '0;
		end else begin
			for (int i = 0; i < `WAYS; i++) begin
				valid_q[i] <= exec_req[i].valid;
			end
		end
	end

	// Operands and tag
	always_ff @(posedge clock) begin
		req_q <= exec_req;
	end

	// One ALU per way
	always_comb begin
		for (int i = 0; i < `WAYS; i++) begin
			complete[i].valid = valid_q[i];
			complete[i].tag   = req_q[i].tag;
			case (req_q[i].op)
				OP_LUI:  complete[i].value = req_q[i].imm;
				OP_ADDI: complete[i].value = req_q[i].rs1_val + req_q[i].imm;
				default: complete[i].value = '0;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- source/rob.sv
// Circular reorder buffer, in-order retire of up to two per cycle
// Retire ports are combinational from the head entries
// A WFI retires with rd 0 and halts; nothing younger ever retires

`default_nettype none

`include "core_consts.svh"

module rob (
	input  wire                                    clock,
	input  wire                                    arst_n,
	input  wire core_pkg::rob_alloc_t [`WAYS-1:0]  alloc,
	input  wire core_pkg::complete_t [`WAYS-1:0]   complete,
	output logic [`ROB_TAG_BITS-1:0]               alloc_tag,
	output logic [`ROB_TAG_BITS:0]                 free_count,
	output logic [`N_ARCH_REG-1:0]                 busy_regs,
	output core_pkg::retire_t [`WAYS-1:0]          retire,
	output logic                                   halt
);
	typedef struct packed {
		logic [`XLEN-1:0]          pc;
		logic [`REG_IDX_BITS-1:0]  rd;
		logic                      is_wfi;
		logic [`XLEN-1:0]          value;
	} rob_entry_t;

	rob_entry_t                            entry_q [`ROB_ENTRIES];
	logic [`ROB_ENTRIES-1:0]               valid_q;
	logic [`ROB_ENTRIES-1:0]               done_q;
	logic [`ROB_TAG_BITS-1:0]              head_q;
	logic [`ROB_TAG_BITS-1:0]              tail_q;
	logic [`ROB_TAG_BITS:0]                count_q;
	logic [`ROB_TAG_BITS:0]                n_alloc;
	logic [`ROB_TAG_BITS:0]                n_retire;
	logic [`WAYS-1:0][`ROB_TAG_BITS-1:0]   head_idx;
	logic [`WAYS-1:0][`ROB_TAG_BITS-1:0]   alloc_idx;

	assign alloc_tag  = tail_q;
	assign free_count = (`ROB_TAG_BITS + 1)'(`ROB_ENTRIES) - count_q;

	////////////////////////////////////////////////////////////////////////////
	// Allocation and retire selection
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		n_alloc = '0;
		for (int i = 0; i < `WAYS; i++) begin
			alloc_idx[i] = tail_q + `ROB_TAG_BITS'(i);
			n_alloc      = n_alloc + (`ROB_TAG_BITS + 1)'(alloc[i].valid);
		end
	end

	always_comb begin
		logic blocked;
		blocked  = halt;
		n_retire = '0;
		for (int i = 0; i < `WAYS; i++) begin
			head_idx[i]     = head_q + `ROB_TAG_BITS'(i);
			retire[i].valid = !blocked && valid_q[head_idx[i]] && done_q[head_idx[i]];
			retire[i].pc    = entry_q[head_idx[i]].pc;
			retire[i].rd    = entry_q[head_idx[i]].rd;
			// A write to x0 retires a zero result
			retire[i].value = (entry_q[head_idx[i]].rd == '0) ? '0 :
				entry_q[head_idx[i]].value;
			// Younger entries wait behind an unfinished entry or a WFI
			blocked  = !retire[i].valid || entry_q[head_idx[i]].is_wfi;
			n_retire = n_retire + (`ROB_TAG_BITS + 1)'(retire[i].valid);
		end
	end

	// Registers with a writer in flight, never x0
	always_comb begin
		busy_regs = '0;
		for (int e = 0; e < `ROB_ENTRIES; e++) begin
			if (valid_q[e]) begin
				busy_regs[entry_q[e].rd] = 1'b1;
			end
		end
		busy_regs[0] = 1'b0;
	end

	////////////////////////////////////////////////////////////////////////////
	// State update
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			valid_q <= '0;
			done_q  <= '0;
			head_q  <= '0;
			tail_q  <= '0;
			count_q <= '0;
			halt    <= 1'b0;
		end else begin
			for (int i = 0; i < `WAYS; i++) begin
				if (retire[i].valid) begin
					valid_q[head_idx[i]] <= 1'b0;
					done_q[head_idx[i]]  <= 1'b0;
					if (entry_q[head_idx[i]].is_wfi) begin
						halt <= 1'b1;
					end
				end
			end
			for (int i = 0; i < `WAYS; i++) begin
				if (complete[i].valid) begin
					done_q[complete[i].tag] <= 1'b1;
				end
			end
			// WFI needs no ALU, so it starts complete
			for (int i = 0; i < `WAYS; i++) begin
				if (alloc[i].valid) begin
					valid_q[alloc_idx[i]] <= 1'b1;
					done_q[alloc_idx[i]]  <= alloc[i].is_wfi;
				end
			end
			head_q  <= head_q + `ROB_TAG_BITS'(n_retire);
			tail_q  <= tail_q + `ROB_TAG_BITS'(n_alloc);
			count_q <= count_q + n_alloc - n_retire;
		end
	end

	// Entry payload
	always_ff @(posedge clock) begin
		for (int i = 0; i < `WAYS; i++) begin
			if (complete[i].valid) begin
				entry_q[complete[i].tag].value <= complete[i].value;
			end
		end
		for (int i = 0; i < `WAYS; i++) begin
			if (alloc[i].valid) begin
				entry_q[alloc_idx[i]] <= '{pc: alloc[i].pc, rd: alloc[i].rd,
					is_wfi: alloc[i].is_wfi, value: '0};
			end
		end
	end

	// Dispatch must respect free_count
	assert property (@(posedge clock) disable iff (!arst_n) n_alloc <= free_count)
		else $error("rob: %0d allocations with %0d free", n_alloc, free_count);

	// An ALU result belongs to a live entry still waiting for it
	for (genvar g = 0; g < `WAYS; g++) begin : g_complete_chk
		assert property (@(posedge clock) disable iff (!arst_n)
			complete[g].valid |-> valid_q[complete[g].tag] && !done_q[complete[g].tag])
			else $error("rob: bad completion of tag %0d", complete[g].tag);
	end

endmodule

`default_nettype wire

//--- source/arch_regfile.sv
// Architectural register file, written only at retire
// On a shared rd the younger retire way wins; x0 is never written
// rs1 reads are combinational

`default_nettype none

`include "core_consts.svh"

module arch_regfile (
	input  wire                                  clock,
	input  wire                                  arst_n,
	input  wire core_pkg::retire_t [`WAYS-1:0]   retire,
	input  wire  [`WAYS-1:0][`REG_IDX_BITS-1:0]  rs1_idx,
	output logic [`WAYS-1:0][`XLEN-1:0]          rs1_value
);
	logic [`XLEN-1:0] regs_q [`N_ARCH_REG];

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			for (int r = 0; r < `N_ARCH_REG; r++) begin
				regs_q[r] <= '0;
			end
		end else begin
			// Later way overrides the earlier one
			for (int i = 0; i < `WAYS; i++) begin
				if (retire[i].valid && retire[i].rd != '0) begin
					regs_q[retire[i].rd] <= retire[i].value;
				end
			end
		end
	end

	always_comb begin
		for (int i = 0; i < `WAYS; i++) begin
			rs1_value[i] = regs_q[rs1_idx[i]];
		end
	end

endmodule

`default_nettype wire

//--- source/core_top.sv
// Two-way core: fetch, dispatch, execute, ROB and register file
// Instruction port is combinational, data for imem_addr in the same cycle
// halt stays high once a WFI retires, until the next reset

`default_nettype none

`include "core_consts.svh"

module core_top (
	input  wire                            clock,
	input  wire                            arst_n,
	input  wire  [`WAYS-1:0][`XLEN-1:0]    imem_data,
	output logic [`WAYS-1:0][`XLEN-1:0]    imem_addr,
	output core_pkg::retire_t [`WAYS-1:0]  retire,
	output logic                           halt
);
	import core_pkg::*;

	fetch_slot_t [`WAYS-1:0]              slots;
	logic [1:0]                           dispatch_count;
	logic [`ROB_TAG_BITS-1:0]             alloc_tag;
	logic [`ROB_TAG_BITS:0]               free_count;
	logic [`N_ARCH_REG-1:0]               busy_regs;
	logic [`WAYS-1:0][`REG_IDX_BITS-1:0]  rs1_idx;
	logic [`WAYS-1:0][`XLEN-1:0]          rs1_value;
	rob_alloc_t [`WAYS-1:0]               alloc;
	exec_req_t [`WAYS-1:0]                exec_req;
	complete_t [`WAYS-1:0]                complete;

	////////////////////////////////////////////////////////////////////////////
	// Front end
	////////////////////////////////////////////////////////////////////////////

	fetch_stage u_fetch (
		.clock          (clock),
		.arst_n         (arst_n),
		.halt           (halt),
		.dispatch_count (dispatch_count),
		.imem_data      (imem_data),
		.imem_addr      (imem_addr),
		.slots          (slots)
	);

	dispatch_stage u_dispatch (
		.slots          (slots),
		.alloc_tag      (alloc_tag),
		.free_count     (free_count),
		.busy_regs      (busy_regs),
		.rs1_value      (rs1_value),
		.dispatch_count (dispatch_count),
		.rs1_idx        (rs1_idx),
		.alloc          (alloc),
		.exec_req       (exec_req)
	);

	////////////////////////////////////////////////////////////////////////////
	// Execute and retire
	////////////////////////////////////////////////////////////////////////////

	execute_unit u_execute (
		.clock    (clock),
		.arst_n   (arst_n),
		.exec_req (exec_req),
		.complete (complete)
	);

	rob u_rob (
		.clock      (clock),
		.arst_n     (arst_n),
		.alloc      (alloc),
		.complete   (complete),
		.alloc_tag  (alloc_tag),
		.free_count (free_count),
		.busy_regs  (busy_regs),
		.retire     (retire),
		.halt       (halt)
	);

	// Committed state, also feeds dispatch operands
	arch_regfile u_regfile (
		.clock     (clock),
		.arst_n    (arst_n),
		.retire    (retire),
		.rs1_idx   (rs1_idx),
		.rs1_value (rs1_value)
	);

endmodule

`default_nettype wire

//--- testbench/tb_clock_gen.sv
// Clock and reset for the core testbench
// Period 100; arst_n low for 5 rising edges at start and after each restart
// A restart is a rising edge on restart while arst_n is high

`default_nettype none

module tb_clock_gen (
	input  wire  restart,
	output logic clock,
	output logic arst_n
);
	localparam int HALF_PERIOD  = 50;
	localparam int RESET_CYCLES = 5;
	localparam int DRIVE_DELAY  = 10;

	initial begin
		clock = 1'b0;
		forever begin
			#HALF_PERIOD clock = ~clock;
		end
	end

	// Release lands a short delay after the edge
	initial begin
		arst_n = 1'b0;
		forever begin
			repeat (RESET_CYCLES) @(posedge clock);
			#DRIVE_DELAY arst_n = 1'b1;
			@(posedge restart);
			arst_n = 1'b0;
		end
	end

endmodule

`default_nettype wire

//--- testbench/tb_core.sv
// Testbench for core_top with directed and random LUI/ADDI/WFI programs
// Instruction memory answers combinationally; words past the program are ADDI fill
// Expected retirements come from a sequential model up to the first WFI
// Programs must stay within PROG_WORDS words

`default_nettype none

`include "core_consts.svh"

module tb_core;
	import core_pkg::*;

	localparam int          PROG_WORDS  = 64;
	localparam int          HALT_WINDOW = 50;
	localparam int          DRIVE_DELAY = 10;
	localparam int          N_RANDOM    = 4;
	localparam logic [31:0] SEED        = 32'he22c186b;

	// One expected retirement
	typedef struct packed {
		logic [`XLEN-1:0]          pc;
		logic [`REG_IDX_BITS-1:0]  rd;
		logic [`XLEN-1:0]          value;
	} expect_t;

	logic                         clock;
	logic                         arst_n;
	logic                         restart;
	logic                         halt;
	logic [`WAYS-1:0][`XLEN-1:0]  imem_data;
	logic [`WAYS-1:0][`XLEN-1:0]  imem_addr;
	retire_t [`WAYS-1:0]          retire;

	logic [31:0]  prog_mem [PROG_WORDS];
	int           prog_len;
	expect_t      exp_q [$];
	string        test_name;
	int           test_index;
	int           cycle_count;
	int           cycle_limit;
	int           n_retired;
	int           n_expected;

	tb_clock_gen u_clock_gen (
		.restart (restart),
		.clock   (clock),
		.arst_n  (arst_n)
	);

	core_top u_dut (
		.clock     (clock),
		.arst_n    (arst_n),
		.imem_data (imem_data),
		.imem_addr (imem_addr),
		.retire    (retire),
		.halt      (halt)
	);

	////////////////////////////////////////////////////////////////////////////
	// Encodings and instruction memory
	////////////////////////////////////////////////////////////////////////////

	function automatic logic [31:0] enc_lui(input int rd, input int imm20);
		return {imm20[19:0], rd[4:0], `RV_OPC_LUI};
	endfunction

	function automatic logic [31:0] enc_addi(input int rd, input int rs1, input int imm);
		return {imm[11:0], rs1[4:0], 3'b000, rd[4:0], `RV_OPC_ADDI};
	endfunction

	// ADDI from x0, immediate and rd mixed from all address bits
	function automatic logic [31:0] fill_word(input logic [31:0] addr);
		logic [11:0] imm;
		logic [4:0]  rd;
		imm = addr[13:2] ^ addr[25:14] ^ {6'b0, addr[31:26]};
		rd  = addr[6:2] ^ addr[31:27];
		return {imm, 5'd0, 3'b000, rd, `RV_OPC_ADDI};
	endfunction

	always_comb begin
		for (int i = 0; i < `WAYS; i++) begin
			if (int'(imem_addr[i][31:2]) < prog_len) begin
				imem_data[i] = prog_mem[imem_addr[i][7:2]];
			end else begin
				imem_data[i] = fill_word(imem_addr[i]);
			end
		end
	end

	task automatic add_inst(input logic [31:0] word);
		prog_mem[prog_len] = word;
		prog_len++;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Reference model and checking
	////////////////////////////////////////////////////////////////////////////

	// Sequential execution, one retirement per instruction up to the first WFI
	function automatic void compute_expected();
		logic [31:0] regs [32];
		logic [31:0] inst;
		expect_t     e;
		for (int r = 0; r < 32; r++) begin
			regs[r] = '0;
		end
		for (int n = 0; n < prog_len; n++) begin
			inst = prog_mem[n];
			e.pc = n * 4;
			if (inst == `RV_INST_WFI) begin
				e.rd    = '0;
				e.value = '0;
				exp_q.push_back(e);
				break;
			end
			e.rd = inst[11:7];
			if (inst[6:0] == `RV_OPC_LUI) begin
				e.value = {inst[31:12], 12'b0};
			end else begin
				e.value = regs[inst[19:15]] + {{20{inst[31]}}, inst[31:20]};
			end
			if (e.rd == '0) begin
				e.value = '0;
			end else begin
				regs[e.rd] = e.value;
			end
			exp_q.push_back(e);
		end
	endfunction

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("Simulation FAILED");
		$fatal(1, "run stopped at the first failure");
	endtask

	task automatic check_value(input string what, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected) begin
			report_failure($sformatf("CHECK FAILED: test %s, %s: expected %h, actual %h",
				test_name, what, expected, actual));
		end
	endtask

	// Retire ports are stable mid-cycle
	always @(negedge clock) begin : compare_retire
		expect_t e;
		if (arst_n === 1'b1) begin
			for (int i = 0; i < `WAYS; i++) begin
				if (retire[i].valid) begin
					if (exp_q.size() == 0) begin
						report_failure($sformatf("Test %s retired an extra instruction at pc %h",
							test_name, retire[i].pc));
					end else begin
						e = exp_q.pop_front();
						check_value($sformatf("pc of retirement %0d", n_retired),
							e.pc, retire[i].pc);
						check_value($sformatf("rd of retirement %0d", n_retired),
							{27'd0, e.rd}, {27'd0, retire[i].rd});
						check_value($sformatf("value of retirement %0d", n_retired),
							e.value, retire[i].value);
						n_retired++;
					end
				end
			end
		end
	end

	// Watchdog
	always @(posedge clock) begin
		cycle_count++;
		if (cycle_count > cycle_limit) begin
			report_failure($sformatf("Timeout in test %s after %0d cycles, limit %0d",
				test_name, cycle_count, cycle_limit));
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Test sequencing
	////////////////////////////////////////////////////////////////////////////

	// Program is loaded while the core sits in reset
	task automatic start_test(input string name);
		if (test_index != 0) begin
			@(posedge clock);
			#DRIVE_DELAY restart = 1'b1;
			wait (arst_n === 1'b0);
			@(posedge clock);
			#DRIVE_DELAY restart = 1'b0;
		end
		test_name = name;
		prog_len  = 0;
		exp_q.delete();
	endtask

	task automatic finish_test();
		compute_expected();
		n_expected  += exp_q.size();
		cycle_limit += 20 * prog_len + 100;
		wait (arst_n === 1'b1);
		// Until the WFI has been seen on a retire port
		wait (n_retired == n_expected);
		// halt rises at the edge that retires the WFI
		@(negedge clock);
		check_value("halt after WFI", 32'd1, {31'd0, halt});
		// Nothing younger than the WFI may retire
		repeat (HALT_WINDOW) @(negedge clock);
		check_value("halt still high", 32'd1, {31'd0, halt});
		test_index++;
	endtask

	task automatic test_independent();
		start_test("independent");
		add_inst(enc_lui(1, 32'h12345));
		add_inst(enc_addi(2, 0, 100));
		add_inst(enc_lui(3, 32'hfffff));
		add_inst(enc_addi(4, 0, -1));
		add_inst(enc_addi(5, 0, 2047));
		add_inst(enc_addi(6, 0, -2048));
		add_inst(enc_lui(7, 1));
		add_inst(enc_addi(8, 0, 7));
		add_inst(`RV_INST_WFI);
		finish_test();
	endtask

	// Way 1 reading way 0's rd forces a one-slot dispatch and a shift
	task automatic test_chains();
		start_test("chains");
		add_inst(enc_addi(1, 0, 1));
		add_inst(enc_addi(1, 1, 2));
		add_inst(enc_addi(2, 1, 3));
		add_inst(enc_addi(3, 2, 4));
		add_inst(enc_lui(4, 32'h10));
		add_inst(enc_addi(4, 4, -16));
		add_inst(enc_addi(5, 4, 5));
		add_inst(enc_addi(6, 0, 9));
		add_inst(enc_addi(6, 6, 1));
		add_inst(enc_addi(7, 6, -20));
		add_inst(`RV_INST_WFI);
		finish_test();
	endtask

	task automatic test_x0_writes();
		start_test("x0_writes");
		add_inst(enc_addi(0, 0, 5));
		add_inst(enc_lui(0, 32'habcde));
		add_inst(enc_addi(1, 0, 3));
		add_inst(enc_addi(0, 1, 7));
		add_inst(enc_addi(2, 0, 0));
		add_inst(enc_addi(3, 0, -9));
		add_inst(`RV_INST_WFI);
		finish_test();
	endtask

	// Dependent runs longer than the ROB
	task automatic test_long_hazards();
		start_test("long_hazards");
		add_inst(enc_addi(1, 0, 1));
		for (int k = 0; k < 10; k++) begin
			add_inst(enc_addi(2, 1, k + 1));
			add_inst(enc_addi(1, 2, -3));
		end
		add_inst(enc_lui(4, 32'h00abc));
		for (int k = 0; k < 6; k++) begin
			add_inst(enc_addi(4, 4, 100));
		end
		add_inst(`RV_INST_WFI);
		finish_test();
	endtask

	// WFI in way 1, followed by words that must never retire
	task automatic test_halt();
		start_test("halt");
		add_inst(enc_addi(1, 0, 11));
		add_inst(enc_lui(2, 32'h55555));
		add_inst(enc_addi(3, 1, 1));
		add_inst(`RV_INST_WFI);
		add_inst(enc_addi(4, 0, 4));
		add_inst(enc_addi(5, 0, 5));
		add_inst(enc_lui(6, 1));
		add_inst(enc_addi(1, 1, 1));
		finish_test();
	endtask

	// Few registers, so hazards are frequent
	task automatic test_random(input int idx);
		int len;
		start_test($sformatf("random_%0d", idx));
		len = $urandom_range(40, 16);
		for (int n = 0; n < len; n++) begin
			if ($urandom_range(3, 0) == 0) begin
				add_inst(enc_lui($urandom_range(9, 0), $urandom));
			end else begin
				add_inst(enc_addi($urandom_range(9, 0), $urandom_range(9, 0), $urandom));
			end
		end
		add_inst(`RV_INST_WFI);
		finish_test();
	endtask

	initial begin
		void'($urandom(SEED));
		restart     = 1'b0;
		prog_len    = 0;
		test_name   = "none";
		test_index  = 0;
		cycle_count = 0;
		cycle_limit = 0;
		n_retired   = 0;
		n_expected  = 0;

		test_independent();
		test_chains();
		test_x0_writes();
		test_long_hazards();
		test_halt();
		for (int p = 0; p < N_RANDOM; p++) begin
			test_random(p);
		end

		$display("Simulation PASSED");
		$finish;
	end

endmodule

`default_nettype wire

//--- project.f
+incdir+source
source/core_pkg.sv
source/fetch_stage.sv
source/dispatch_stage.sv
source/execute_unit.sv
source/rob.sv
source/arch_regfile.sv
source/core_top.sv
testbench/tb_clock_gen.sv
testbench/tb_core.sv

//--- Makefile
# Verilator simulation of the two-way core

SIM      := verilator
SIMFLAGS := --binary --timing --assert -Wno-fatal
TOP      := tb_core
FILELIST := project.f
BUILDDIR := obj_dir
LOG      := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build and run the simulation, then check $(LOG)"
	@echo "  clean  remove the build directory and $(LOG)"

test:
	$(SIM) $(SIMFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILDDIR)
	./$(BUILDDIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "Simulation PASSED" $(LOG) || (echo "test failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILDDIR) $(LOG)
